// File: ifuPkg.sv
// fetch subsystem definitions
package ifuPkg;

  ////////////////////
  // widths and constants
  ////////////////////

  localparam int XLEN = 32;
  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0100;
  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP = 32'h0000_0013;

  // instruction memory shape
  localparam int MEM_WAIT = 2;
  localparam int MEM_WORDS = 256;
  localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
  // wait counter must reach MEM_WAIT
  localparam int WAIT_BITS = $clog2(MEM_WAIT + 2);

  ////////////////////
  // enums
  ////////////////////

  // bus master state
  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT
  } busStateT;

  // rv32 major opcodes, bits 6:0
  typedef enum logic [6:0] {
    OP_LOAD   = 7'h03,
    OP_OPIMM  = 7'h13,
    OP_AUIPC  = 7'h17,
    OP_STORE  = 7'h23,
    OP_OP     = 7'h33,
    OP_LUI    = 7'h37,
    OP_BRANCH = 7'h63,
    OP_JALR   = 7'h67,
    OP_JAL    = 7'h6F,
    OP_SYSTEM = 7'h73
  } opcodeT;

  ////////////////////
  // structs
  ////////////////////

  // control-flow class of the decode instruction, msb first
  typedef struct packed {
    logic isCall;
    logic isReturn;
    logic isJumpReg;
    logic isJump;
    logic isBranch;
  } instrClassT;

  // wishbone classic request, master to slave
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic [XLEN-1:0] adr;
    logic            we;
  } wbReqT;

  // wishbone classic response, slave to master
  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat;
  } wbRspT;

  // one pipeline stage
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic            valid;
  } stageT;

endpackage

// File: decompress.sv
// rv32c expander
`timescale 1ns/10ps

module decompress (
  input  logic [ifuPkg::XLEN-1:0] instrRaw,
  output logic [ifuPkg::XLEN-1:0] instrD,
  output logic                    compressed,
  output logic                    illegalComp
);
  import ifuPkg::*;

  logic [15:0] c;
  logic [1:0]  quad;
  logic [2:0]  funct3;
  logic [4:0]  rdRs1;
  logic [4:0]  rs2;
  logic [4:0]  rs1p;
  logic [11:0] immCi;
  logic [19:0] immLui;
  logic [20:0] offJ;
  logic [12:0] offB;

  // field extraction
  assign c = instrRaw[15:0];
  assign quad = c[1:0];
  assign funct3 = c[15:13];
  assign rdRs1 = c[11:7];
  assign rs2 = c[6:2];
  // 3-bit register fields map to x8..x15
  assign rs1p = {2'b01, c[9:7]};

  // ci immediate, sign extended
  assign immCi = {{6{c[12]}}, c[12], c[6:2]};
  assign immLui = {{14{c[12]}}, c[12], c[6:2]};
  // cj offset, scrambled bit order
  assign offJ = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
  // cb offset
  assign offB = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};

  always_comb begin
    compressed = quad != 2'b11;
    instrD = NOP;
    illegalComp = 1'b0;
    if (!compressed) begin
      instrD = instrRaw;
    end else begin
      // cleared by each supported form
      illegalComp = 1'b1;
      case (quad)
        2'b01: begin
          case (funct3)
            // c.addi, c.nop when rd is x0
            3'b000: begin
              instrD = {immCi, rdRs1, 3'b000, rdRs1, OP_OPIMM};
              illegalComp = 1'b0;
            end
            // c.jal links to ra
            3'b001: begin
              instrD = {offJ[20], offJ[10:1], offJ[11], offJ[19:12], 5'd1, OP_JAL};
              illegalComp = 1'b0;
            end
            // c.li
            3'b010: begin
              instrD = {immCi, 5'd0, 3'b000, rdRs1, OP_OPIMM};
              illegalComp = 1'b0;
            end
            // c.lui; sp form is c.addi16sp, not handled
            3'b011: begin
              if (rdRs1 != 5'd2 && immLui != '0) begin
                instrD = {immLui, rdRs1, OP_LUI};
                illegalComp = 1'b0;
              end
            end
            // c.j
            3'b101: begin
              instrD = {offJ[20], offJ[10:1], offJ[11], offJ[19:12], 5'd0, OP_JAL};
              illegalComp = 1'b0;
            end
            // c.beqz
            3'b110: begin
              instrD = {offB[12], offB[10:5], 5'd0, rs1p, 3'b000, offB[4:1], offB[11],
                        OP_BRANCH};
              illegalComp = 1'b0;
            end
            // c.bnez
            3'b111: begin
              instrD = {offB[12], offB[10:5], 5'd0, rs1p, 3'b001, offB[4:1], offB[11],
                        OP_BRANCH};
              illegalComp = 1'b0;
            end
            default: ;
          endcase
        end
        2'b10: begin
          if (funct3 == 3'b100) begin
            if (!c[12]) begin
              if (rs2 == 5'd0) begin
                // c.jr
                if (rdRs1 != 5'd0) begin
                  instrD = {12'd0, rdRs1, 3'b000, 5'd0, OP_JALR};
                  illegalComp = 1'b0;
                end
              end else begin
                // c.mv
                instrD = {7'd0, rs2, 5'd0, 3'b000, rdRs1, OP_OP};
                illegalComp = 1'b0;
              end
            end else begin
              if (rs2 == 5'd0) begin
                // c.jalr; rd and rs2 zero would be c.ebreak
                if (rdRs1 != 5'd0) begin
                  instrD = {12'd0, rdRs1, 3'b000, 5'd1, OP_JALR};
                  illegalComp = 1'b0;
                end
              end else begin
                // c.add
                instrD = {7'd0, rs2, rdRs1, 3'b000, rdRs1, OP_OP};
                illegalComp = 1'b0;
              end
            end
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// File: fetchBus.sv
// wishbone fetch master
`timescale 1ns/10ps

module fetchBus (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    fetchReq,
  input  logic [ifuPkg::XLEN-1:0] fetchAdr,
  input  logic                    discard,
  output ifuPkg::wbReqT           wbReq,
  input  ifuPkg::wbRspT           wbRsp,
  output logic [ifuPkg::XLEN-1:0] fetchWord,
  output logic                    fetchDone,
  output logic                    fetchStall
);
  import ifuPkg::*;

  busStateT        state;
  logic            dropQ;
  logic            holdValid;
  logic [XLEN-1:0] holdWord;
  logic            ackW;
  logic            accept;
  logic            issue;

  assign ackW = (state == BUS_WAIT) & wbRsp.ack;
  // word of a superseded read never counts
  assign accept = ackW & ~dropQ & ~discard;
  assign fetchDone = accept | (holdValid & ~discard);
  assign fetchWord = holdValid ? holdWord : wbRsp.dat;
  assign fetchStall = (state == BUS_WAIT) & ~accept;
  // new read from idle, or straight behind an ack
  assign issue = fetchReq & ((state == BUS_IDLE) | ackW);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= BUS_IDLE;
      wbReq.cyc <= 1'b0;
      wbReq.stb <= 1'b0;
      wbReq.we <= 1'b0;
      dropQ <= 1'b0;
      holdValid <= 1'b0;
    end else begin
      // request side
      if (issue) begin
        state <= BUS_WAIT;
        wbReq <= '{cyc: 1'b1, stb: 1'b1, adr: {fetchAdr[XLEN-1:2], 2'b00}, we: 1'b0};
      end else if (ackW) begin
        state <= BUS_IDLE;
        wbReq.cyc <= 1'b0;
        wbReq.stb <= 1'b0;
      end
      // redirect during a read marks its word stale
      if (ackW) begin
        dropQ <= 1'b0;
      end else if ((state == BUS_WAIT) & discard) begin
        dropQ <= 1'b1;
      end
      // keep a word that arrives under stall
      if (accept & ~fetchReq) begin
        holdValid <= 1'b1;
      end else if (discard | fetchReq) begin
        holdValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept & ~fetchReq) begin
      holdWord <= wbRsp.dat;
    end
  end

endmodule

// File: ifu.sv
// instruction fetch unit
`timescale 1ns/10ps

module ifu (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stallF,
  input  logic                     stallD,
  input  logic                     stallE,
  input  logic                     flushD,
  input  logic                     flushE,
  input  logic                     pcSrcE,
  input  logic [ifuPkg::XLEN-1:0]  pcTargetE,
  input  logic                     trapM,
  input  logic [ifuPkg::XLEN-1:0]  trapTargetM,
  output ifuPkg::wbReqT            wbReq,
  input  ifuPkg::wbRspT            wbRsp,
  output ifuPkg::stageT            decodeD,
  output ifuPkg::stageT            executeE,
  output ifuPkg::instrClassT       instrClassD,
  output logic [ifuPkg::XLEN-1:0]  pcLinkE,
  output logic                     fetchStall,
  output logic                     illegalCompD,
  output logic                     misalignedFaultE,
  output logic [ifuPkg::XLEN-1:0]  misalignedAdrE
);
  import ifuPkg::*;

  logic            resetQ;
  logic [XLEN-1:0] pcF;
  logic [XLEN-1:0] pcNextF;
  logic [XLEN-1:0] unalignedPcNextF;
  logic [XLEN-1:0] pcPlus2or4F;
  logic [XLEN-3:0] pcPlusUpperF;
  logic [XLEN-1:0] pcCorrectE;
  logic [XLEN-1:0] fetchAdrF;
  logic [XLEN-1:0] fetchWordF;
  logic [XLEN-1:0] instrRawF;
  logic [XLEN-1:0] instrF;
  logic            fetchDoneF;
  logic            fetchReqF;
  logic            compressedF;
  logic            illegalCompF;
  logic            redirect;
  logic            advanceF;
  logic            pcEnF;
  logic [XLEN-1:0] pcLinkD;
  logic            isJalD;
  logic            isJalrD;
  logic            linkRdD;
  logic            linkRs1D;

  ////////////////////
  // fetch
  ////////////////////

  // no predictor, so any taken branch or trap is a redirect
  assign redirect = trapM | pcSrcE;
  // fetch consumer is ready only when decode can take the word
  assign fetchReqF = ~stallF & ~stallD & ~flushD;
  assign advanceF = fetchDoneF & fetchReqF;
  assign pcEnF = resetQ | redirect | advanceF;
  // address of the next read, already the new pc when it moves this cycle
  assign fetchAdrF = pcEnF ? pcNextF : pcF;

  fetchBus bus (
    .clk       (clk),
    .reset     (reset),
    .fetchReq  (fetchReqF),
    .fetchAdr  (fetchAdrF),
    .discard   (redirect),
    .wbReq     (wbReq),
    .wbRsp     (wbRsp),
    .fetchWord (fetchWordF),
    .fetchDone (fetchDoneF),
    .fetchStall(fetchStall)
  );

  // pc bit 1 picks the halfword
  assign instrRawF = pcF[1] ? {16'h0000, fetchWordF[31:16]} : fetchWordF;

  decompress decomp (
    .instrRaw   (instrRawF),
    .instrD     (instrF),
    .compressed (compressedF),
    .illegalComp(illegalCompF)
  );

  // pc+4 on the upper bits, pc+2 steps between halfwords
  assign pcPlusUpperF = pcF[XLEN-1:2] + 1'b1;
  always_comb begin
    if (compressedF) begin
      if (pcF[1]) pcPlus2or4F = {pcPlusUpperF, 2'b00};
      else        pcPlus2or4F = {pcF[XLEN-1:2], 2'b10};
    end else begin
      pcPlus2or4F = {pcPlusUpperF, pcF[1:0]};
    end
  end

  // resolved target, or fall through when the branch is not taken
  assign pcCorrectE = pcSrcE ? pcTargetE : pcLinkE;

  // next pc priority: reset vector, trap, branch, sequential
  always_comb begin
    if (resetQ)      unalignedPcNextF = RESET_VECTOR;
    else if (trapM)  unalignedPcNextF = trapTargetM;
    else if (pcSrcE) unalignedPcNextF = pcCorrectE;
    else             unalignedPcNextF = pcPlus2or4F;
  end
  // halfword alignment
  assign pcNextF = {unalignedPcNextF[XLEN-1:1], 1'b0};

  // delayed reset forces the vector for one cycle
  always_ff @(posedge clk) begin
    resetQ <= reset;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= RESET_VECTOR;
    end else if (pcEnF) begin
      pcF <= pcNextF;
    end
  end

  ////////////////////
  // decode
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      decodeD.valid <= 1'b0;
      illegalCompD <= 1'b0;
    end else if (flushD) begin
      decodeD <= '{pc: decodeD.pc, instr: NOP, valid: 1'b0};
      illegalCompD <= 1'b0;
    end else if (~stallD) begin
      if (advanceF) begin
        decodeD <= '{pc: pcF, instr: instrF, valid: 1'b1};
        illegalCompD <= illegalCompF;
        pcLinkD <= pcPlus2or4F;
      end else begin
        // bubble while the bus is busy
        decodeD <= '{pc: decodeD.pc, instr: NOP, valid: 1'b0};
        illegalCompD <= 1'b0;
      end
    end
  end

  // ra or x5 count as link registers
  assign isJalD = decodeD.instr[6:0] == OP_JAL;
  assign isJalrD = decodeD.instr[6:0] == OP_JALR;
  assign linkRdD = (decodeD.instr[11:7] & 5'h1B) == 5'h01;
  assign linkRs1D = (decodeD.instr[19:15] & 5'h1B) == 5'h01;

  assign instrClassD.isCall = decodeD.valid & (isJalD | isJalrD) & linkRdD;
  assign instrClassD.isReturn = decodeD.valid & isJalrD & linkRs1D;
  assign instrClassD.isJumpReg = decodeD.valid & isJalrD & ~linkRs1D & ~linkRdD;
  assign instrClassD.isJump = decodeD.valid & isJalD & ~linkRdD;
  assign instrClassD.isBranch = decodeD.valid & (decodeD.instr[6:0] == OP_BRANCH);

  ////////////////////
  // execute
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      executeE.valid <= 1'b0;
    end else if (flushE) begin
      executeE <= '{pc: executeE.pc, instr: NOP, valid: 1'b0};
    end else if (~stallE) begin
      executeE <= decodeD;
      pcLinkE <= pcLinkD;
    end
  end

  // taken target with bit 0 set
  assign misalignedFaultE = pcSrcE & pcTargetE[0];
  assign misalignedAdrE = pcCorrectE;

endmodule

// File: instrMem.sv
// instruction memory, wishbone slave
`timescale 1ns/10ps

module instrMem (
  input  logic                    clk,
  input  logic                    reset,
  input  ifuPkg::wbReqT           wbReq,
  output ifuPkg::wbRspT           wbRsp,
  input  logic                    loadWe,
  input  logic [ifuPkg::XLEN-1:0] loadAddr,
  input  logic [ifuPkg::XLEN-1:0] loadData
);
  import ifuPkg::*;

  logic [XLEN-1:0]      mem [MEM_WORDS];
  logic [WAIT_BITS-1:0] waitCnt;
  logic                 ackQ;
  logic [XLEN-1:0]      datQ;
  logic                 readReq;
  logic                 lastWait;

  // read only port
  assign readReq = wbReq.cyc & wbReq.stb & ~wbReq.we;
  assign lastWait = readReq & ~ackQ & (waitCnt == WAIT_BITS'(MEM_WAIT));

  ////////////////////
  // wait states and ack
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      waitCnt <= '0;
      ackQ <= 1'b0;
    end else if (readReq & ~ackQ) begin
      if (lastWait) begin
        ackQ <= 1'b1;
        waitCnt <= '0;
      end else begin
        waitCnt <= waitCnt + 1'b1;
      end
    end else begin
      // ack is a single cycle
      ackQ <= 1'b0;
      if (~readReq) begin
        waitCnt <= '0;
      end
    end
  end

  ////////////////////
  // array
  ////////////////////

  // word index wraps with the array depth
  always_ff @(posedge clk) begin
    if (lastWait) begin
      datQ <= mem[wbReq.adr[MEM_ADDR_BITS+1:2]];
    end
    if (loadWe) begin
      mem[loadAddr[MEM_ADDR_BITS+1:2]] <= loadData;
    end
  end

  assign wbRsp.ack = ackQ;
  assign wbRsp.dat = datQ;

endmodule

// File: fetchTop.sv
// fetch subsystem top
`timescale 1ns/10ps

module fetchTop (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stallF,
  input  logic                     stallD,
  input  logic                     stallE,
  input  logic                     flushD,
  input  logic                     flushE,
  input  logic                     pcSrcE,
  input  logic [ifuPkg::XLEN-1:0]  pcTargetE,
  input  logic                     trapM,
  input  logic [ifuPkg::XLEN-1:0]  trapTargetM,
  input  logic                     loadWe,
  input  logic [ifuPkg::XLEN-1:0]  loadAddr,
  input  logic [ifuPkg::XLEN-1:0]  loadData,
  output ifuPkg::stageT            decodeD,
  output ifuPkg::stageT            executeE,
  output ifuPkg::instrClassT       instrClassD,
  output logic [ifuPkg::XLEN-1:0]  pcLinkE,
  output logic                     fetchStall,
  output logic                     illegalCompD,
  output logic                     misalignedFaultE,
  output logic [ifuPkg::XLEN-1:0]  misalignedAdrE
);
  import ifuPkg::*;

  // wishbone between fetch master and memory
  wbReqT wbReq;
  wbRspT wbRsp;

  ifu fetch (
    .clk             (clk),
    .reset           (reset),
    .stallF          (stallF),
    .stallD          (stallD),
    .stallE          (stallE),
    .flushD          (flushD),
    .flushE          (flushE),
    .pcSrcE          (pcSrcE),
    .pcTargetE       (pcTargetE),
    .trapM           (trapM),
    .trapTargetM     (trapTargetM),
    .wbReq           (wbReq),
    .wbRsp           (wbRsp),
    .decodeD         (decodeD),
    .executeE        (executeE),
    .instrClassD     (instrClassD),
    .pcLinkE         (pcLinkE),
    .fetchStall      (fetchStall),
    .illegalCompD    (illegalCompD),
    .misalignedFaultE(misalignedFaultE),
    .misalignedAdrE  (misalignedAdrE)
  );

  // program image comes in through the load port
  instrMem imem (
    .clk     (clk),
    .reset   (reset),
    .wbReq   (wbReq),
    .wbRsp   (wbRsp),
    .loadWe  (loadWe),
    .loadAddr(loadAddr),
    .loadData(loadData)
  );

endmodule

// File: fetchTop_sva.sv
// fetch bus and reset assertions
`timescale 1ns/10ps

module fetchTop_sva (
  input logic          clk,
  input logic          reset,
  input ifuPkg::wbReqT wbReq,
  input ifuPkg::wbRspT wbRsp,
  input ifuPkg::stageT decodeD,
  input ifuPkg::stageT executeE,
  input logic          fetchStall,
  input logic          misalignedFaultE
);
  import ifuPkg::*;

  ////////////////////
  // wishbone classic
  ////////////////////

  // slave answers only a strobe that sits inside an open cycle
  ackInCycle: assert property (@(posedge clk) disable iff (reset)
    wbRsp.ack |-> (wbReq.cyc && wbReq.stb))
    else $error("wishbone ack outside a strobed cycle");

  // request held until the slave acknowledges
  adrHeldToAck: assert property (@(posedge clk) disable iff (reset)
    (wbReq.stb && !wbRsp.ack) |=> (wbReq.stb && $stable(wbReq.adr)))
    else $error("wishbone request changed before ack");

  ////////////////////
  // reset
  ////////////////////

  // second reset cycle on, after the registers have cleared
  quietInReset: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!wbReq.cyc && !wbReq.stb && !decodeD.valid &&
      !executeE.valid && !fetchStall && !misalignedFaultE))
    else $error("fetch output active during reset");

endmodule

bind fetchTop fetchTop_sva sva (
  .clk             (clk),
  .reset           (reset),
  .wbReq           (wbReq),
  .wbRsp           (wbRsp),
  .decodeD         (decodeD),
  .executeE        (executeE),
  .fetchStall      (fetchStall),
  .misalignedFaultE(misalignedFaultE)
);

// File: tb_fetchTop.sv
// fetch subsystem testbench
`timescale 1ns/10ps

module tb_fetchTop;
  import ifuPkg::*;

  logic                clk;
  logic                reset;
  logic                stallF;
  logic                stallD;
  logic                stallE;
  logic                flushD;
  logic                flushE;
  logic                pcSrcE;
  logic [XLEN-1:0]     pcTargetE;
  logic                trapM;
  logic [XLEN-1:0]     trapTargetM;
  logic                loadWe;
  logic [XLEN-1:0]     loadAddr;
  logic [XLEN-1:0]     loadData;
  stageT               decodeD;
  stageT               executeE;
  instrClassT          instrClassD;
  logic [XLEN-1:0]     pcLinkE;
  logic                fetchStall;
  logic                illegalCompD;
  logic                misalignedFaultE;
  logic [XLEN-1:0]     misalignedAdrE;

  // golden file contents
  logic [XLEN-1:0] memAddr [$];
  logic [XLEN-1:0] memData [$];
  logic [XLEN-1:0] recPc [$];
  logic [XLEN-1:0] recInstr [$];
  logic [XLEN-1:0] recClass [$];
  logic [XLEN-1:0] recIllegal [$];
  int              evStep [$];
  int              evKind [$];
  logic [XLEN-1:0] evPcTarget [$];
  logic [XLEN-1:0] evTrapTarget [$];

  int seed;
  int errors;
  int checks;
  int testsRun;
  int testsFailed;
  int limitCycles;
  bit limitReady;
  // fetch stall as seen in the middle of the previous cycle
  logic fetchStallPrev;

  fetchTop dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    fetchStallPrev = fetchStall;
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic checkValue(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%h expected=%h", $time, name, got, expected);
    end
  endtask

  // control inputs back to their quiet values
  task automatic driveIdle();
    stallF = 1'b0;
    stallD = 1'b0;
    stallE = 1'b0;
    flushD = 1'b0;
    flushE = 1'b0;
    pcSrcE = 1'b0;
    trapM = 1'b0;
  endtask

  task automatic readGolden();
    int              fd;
    int              code;
    byte             tag;
    string           line;
    int              step;
    int              kind;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    logic [XLEN-1:0] d;
    fd = $fopen("fetch_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open fetch_golden.txt");
    end else begin
      while (1) begin
        code = $fscanf(fd, " %c", tag);
        if (code != 1) break;
        case (tag)
          "#": code = $fgets(line, fd);
          "M": begin
            code = $fscanf(fd, "%h %h", a, b);
            memAddr.push_back(a);
            memData.push_back(b);
          end
          "E": begin
            code = $fscanf(fd, "%d %d %h %h", step, kind, a, b);
            evStep.push_back(step);
            evKind.push_back(kind);
            evPcTarget.push_back(a);
            evTrapTarget.push_back(b);
          end
          "R": begin
            code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            recPc.push_back(a);
            recInstr.push_back(b);
            recClass.push_back(c);
            recIllegal.push_back(d);
          end
          default: begin
            errors++;
            $display("golden file holds a line with unknown tag %c", tag);
            code = $fgets(line, fd);
          end
        endcase
      end
      $fclose(fd);
    end
  endtask

  // event that fires once record number step has left decode
  function automatic int findEvent(input int step);
    int found;
    found = -1;
    foreach (evStep[i]) begin
      if (evStep[i] == step) found = i;
    end
    return found;
  endfunction

  // link address from the program image, 2 past a compressed halfword
  function automatic logic [XLEN-1:0] linkAddress(input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] word;
    logic [15:0]     half;
    word = '0;
    foreach (memAddr[i]) begin
      if (memAddr[i] == {pc[XLEN-1:2], 2'b00}) word = memData[i];
    end
    half = pc[1] ? word[31:16] : word[15:0];
    return (half[1:0] == 2'b11) ? pc + 32'd4 : pc + 32'd2;
  endfunction

  task automatic applyReset(input bit loadProgram);
    reset = 1'b1;
    driveIdle();
    // program goes in while the core is held
    if (loadProgram) begin
      foreach (memAddr[i]) begin
        @(posedge clk);
        #1;
        loadWe = 1'b1;
        loadAddr = memAddr[i];
        loadData = memData[i];
      end
      @(posedge clk);
      #1;
      loadWe = 1'b0;
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // redirect like the hazard unit, flushes included
  task automatic fireEvent(input int e);
    flushD = 1'b1;
    flushE = 1'b1;
    pcSrcE = 1'b1;
    pcTargetE = evPcTarget[e];
    if (evKind[e] == 2) begin
      trapM = 1'b1;
      trapTargetM = evTrapTarget[e];
    end
    #1;
    checkValue("misalignedFaultE", {31'b0, misalignedFaultE}, {31'b0, evKind[e] == 3});
    if (evKind[e] == 3) begin
      checkValue("misalignedAdrE", misalignedAdrE, evPcTarget[e]);
    end
  endtask

  task automatic checkRecord(input int idx);
    checkValue("decodeD.pc", decodeD.pc, recPc[idx]);
    checkValue("decodeD.instr", decodeD.instr, recInstr[idx]);
    checkValue("instrClassD", {27'b0, instrClassD}, recClass[idx]);
    checkValue("illegalCompD", {31'b0, illegalCompD}, recIllegal[idx]);
  endtask

  // record that left decode one edge ago now sits in execute
  task automatic compareExecute(input int idx);
    checkValue("executeE.valid", {31'b0, executeE.valid}, 32'd1);
    checkValue("executeE.pc", executeE.pc, recPc[idx]);
    checkValue("executeE.instr", executeE.instr, recInstr[idx]);
    checkValue("pcLinkE", pcLinkE, linkAddress(recPc[idx]));
  endtask

  ////////////////////
  // one pass over the program
  ////////////////////

  task automatic runPass(input string name, input bit useStalls);
    int idx;
    int ev;
    int exeIdx;
    int burst;
    int burstOnF;
    int startErrors;
    idx = 0;
    ev = -1;
    exeIdx = -1;
    burst = 0;
    burstOnF = 0;
    startErrors = errors;
    while (idx < recPc.size()) begin
      @(posedge clk);
      #1;
      if (exeIdx >= 0) begin
        compareExecute(exeIdx);
        exeIdx = -1;
      end
      driveIdle();
      if (ev >= 0) begin
        // old path sitting in decode is flushed, not counted
        fireEvent(ev);
        ev = -1;
      end else begin
        if (useStalls) begin
          if (burst == 0 && ($random(seed) & 3) == 0) begin
            burst = 1 + (($random(seed) & 32'h7fff) % 3);
            burstOnF = $random(seed) & 1;
          end
          if (burst > 0) begin
            if (burstOnF != 0) stallF = 1'b1;
            else stallD = 1'b1;
            burst--;
          end
        end
        // record leaves decode at the coming edge
        if (decodeD.valid && !stallD) begin
          checkRecord(idx);
          if (!useStalls) begin
            // stall drops on the ack, next read goes out as the word enters decode
            checkValue("fetchStall at ack", {31'b0, fetchStallPrev}, 32'd0);
            checkValue("fetchStall", {31'b0, fetchStall}, 32'd1);
          end
          exeIdx = idx;
          idx++;
          ev = findEvent(idx);
        end
      end
    end
    @(posedge clk);
    #1;
    if (exeIdx >= 0) begin
      compareExecute(exeIdx);
    end
    driveIdle();
    testsRun++;
    if (errors != startErrors) testsFailed++;
    $display("test %0d %s: %0d records, %0d errors", testsRun, name, idx,
             errors - startErrors);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed = 32'h6e17;
    errors = 0;
    checks = 0;
    testsRun = 0;
    testsFailed = 0;
    limitReady = 1'b0;
    reset = 1'b1;
    loadWe = 1'b0;
    loadAddr = '0;
    loadData = '0;
    pcTargetE = '0;
    trapTargetM = '0;
    driveIdle();
    readGolden();
    if (recPc.size() == 0) begin
      errors++;
      $display("golden file holds no expected records");
    end
    // two passes plus the program load
    limitCycles = 2 * (recPc.size() * (MEM_WAIT + 1) * 4 + 200) + memAddr.size() + 8;
    limitReady = 1'b1;
    applyReset(1'b1);
    runPass("sequential, compressed and redirects", 1'b0);
    applyReset(1'b0);
    runPass("same stream under random stalls", 1'b1);
    $display("tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
             checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // stuck decode stream ends the run
  initial begin
    wait (limitReady);
    repeat (limitCycles) @(posedge clk);
    $display("timeout after %0d cycles, decode stream stopped", limitCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: fetch_golden.txt
# M addr data : program word in hex
# E step kind pcTarget trapTarget : redirect after record step, kind 1 branch 2 trap 3 odd target
# R pc instr class illegal : expected decode record, class bits call return jumpReg jump branch
M 00000100 00500093
M 00000104 0505450D
M 00000108 95AA85AA
M 0000010C 00014000
M 00000110 C0116605
M 00000114 040000EF
M 00000118 0080006F
M 0000011C 00100073
M 00000120 00030067
M 00000124 00100073
M 00000140 00700113
M 00000144 00900193
M 00000148 00000013
M 0000014C 00000013
M 00000154 00008067
M 00000158 00100073
M 00000200 00108093
M 00000204 00100073
E 10 1 00000154 00000000
E 11 1 00000118 00000000
E 12 1 00000120 00000000
E 13 2 00000180 00000200
E 14 3 00000141 00000000
R 00000100 00500093 00 0
R 00000104 00300513 00 0
R 00000106 00150513 00 0
R 00000108 00A005B3 00 0
R 0000010A 00A585B3 00 0
R 0000010C 00000013 00 1
R 0000010E 00000013 00 0
R 00000110 00001637 00 0
R 00000112 00040263 01 0
R 00000114 040000EF 10 0
R 00000154 00008067 08 0
R 00000118 0080006F 02 0
R 00000120 00030067 04 0
R 00000200 00108093 00 0
R 00000140 00700113 00 0
R 00000144 00900193 00 0

// File: sources.f
ifuPkg.sv
decompress.sv
fetchBus.sv
ifu.sv
instrMem.sv
fetchTop.sv
fetchTop_sva.sv
tb_fetchTop.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetchTop
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
